//--- sources.f
logic/icache_pkg.sv
logic/fetch_latch.sv
logic/icache_ways.sv
logic/icache_ctrl.sv
logic/word_select.sv
logic/icache_top.sv
bench/l2_model.sv
bench/tb_icache.sv

//--- bench/tb_icache.sv
// instruction cache testbench
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

    localparam int LIMIT = 100;   // cycles allowed for one fetch

    logic              clk = 1'b0;
    logic              arst_n;
    logic              fetch_req;
    icache_pkg::addr_t fetch_addr;
    logic              l2_busy;
    logic              l2_rdy;
    icache_pkg::line_t l2_line;
    icache_pkg::word_t fetch_word;
    logic              data_rdy;
    logic              miss_stall;
    logic              l2_req;
    icache_pkg::addr_t l2_addr;
    logic              busy_start;
    logic [7:0]        busy_cycles;
    logic [7:0]        latency;
    int                mismatches = 0;
    int                failures = 0;
    int                req_count = 0;
    icache_pkg::addr_t last_l2_addr;
    integer            seed = 32'h255033ff;

    // reference tag state
    logic              ref_valid [2][icache_pkg::NUM_SETS];
    icache_pkg::tag_t  ref_tag   [2][icache_pkg::NUM_SETS];
    logic              ref_lru   [icache_pkg::NUM_SETS];

    always #2 clk = ~clk;

    icache_top uut (.*);
    l2_model   u_l2 (.*);

    // level-2 requests seen on the rising edge
    always @(posedge clk) begin
        if (l2_req) begin
            req_count++;
            last_l2_addr = l2_addr;
            if (l2_busy) begin
                $display("l2_req was raised while l2_busy was high at %0t", $time);
                failures++;
            end
        end
    end

    task automatic check_word(input string name, input icache_pkg::word_t got,
                              input icache_pkg::word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_addr(input string name, input icache_pkg::addr_t got,
                              input icache_pkg::addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    // word k of a line is the line address xor k * 32'h01010101
    function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t addr);
        return {addr[31:4], 4'h0} ^ (addr[3:2] * 32'h01010101);
    endfunction

    // reference lookup with fill and lru update returns 1 on a hit
    function automatic logic ref_access(input icache_pkg::addr_t addr);
        icache_pkg::index_t idx;
        logic               way;
        idx = addr[11:4];
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[w][idx] && ref_tag[w][idx] == addr[31:12]) begin
                ref_lru[idx] = (w == 0);
                return 1'b1;
            end
        end
        way = ref_valid[0][idx] ? (ref_valid[1][idx] ? ref_lru[idx] : 1'b1) : 1'b0;
        ref_valid[way][idx] = 1'b1;
        ref_tag[way][idx]   = addr[31:12];
        ref_lru[idx]        = !way;
        return 1'b0;
    endfunction

    // one fetch checked against the reference
    task automatic fetch_check(input icache_pkg::addr_t addr);
        logic exp_hit;
        int   reqs;
        int   cycles;
        exp_hit    = ref_access(addr);
        reqs       = req_count;
        fetch_req  = 1'b1;
        fetch_addr = addr;
        @(negedge clk);
        fetch_req = 1'b0;
        cycles    = 1;
        while (!data_rdy && cycles < LIMIT) begin
            if (cycles >= 2) begin
                check_flag("miss_stall", miss_stall, 1'b1);   // held through the miss
            end
            @(negedge clk);
            cycles++;
        end
        reqs = req_count - reqs;
        if (!data_rdy) begin
            $display("no data_rdy within %0d cycles for the fetch of %h", LIMIT, addr);
            failures++;
        end else begin
            check_flag("miss", reqs != 0, !exp_hit);
            check_word("fetch_word", fetch_word, expected_word(addr));
            check_flag("miss_stall", miss_stall, 1'b0);
            if (!exp_hit && reqs == 1) begin
                check_addr("l2_addr", last_l2_addr, {addr[31:4], 4'h0});
            end else if (!exp_hit) begin
                $display("%0d level-2 requests for one miss at %h", reqs, addr);
                failures++;
            end else if (cycles != 2) begin
                $display("hit at %h gave data_rdy %0d cycles after fetch_req", addr, cycles);
                failures++;
            end
        end
        @(negedge clk);
    endtask

    // first fetches after reset
    task automatic cold_misses();
        fetch_check(32'h0000_1040);
        fetch_check(32'h0002_3a58);
    endtask

    task automatic line_hits();
        for (int k = 0; k < 4; k++) begin
            fetch_check(32'h0000_1040 + 4 * k);
        end
    endtask

    // three tags on set 7
    task automatic lru_replace();
        fetch_check(32'h0010_0074);   // way 0
        fetch_check(32'h0020_0074);   // way 1
        fetch_check(32'h0010_0070);   // hit makes way 1 the lru
        fetch_check(32'h0030_0078);   // evicts the second tag
        fetch_check(32'h0010_007c);   // first still hits
        fetch_check(32'h0020_0074);   // second misses again
    endtask

    // level 2 busy when the miss is found
    task automatic busy_hold();
        busy_cycles = 8'd6;
        busy_start  = 1'b1;
        @(negedge clk);
        busy_start = 1'b0;
        fetch_check(32'h0004_5120);
    endtask

    // four tags over four sets forces evictions
    task automatic random_fetches();
        logic [31:0] r;
        for (int i = 0; i < 200; i++) begin
            r       = $random(seed);
            latency = {6'd0, r[17:16]};
            fetch_check({18'h0, r[13:12], 6'h0, r[5:2], 2'b00});
        end
    endtask

    initial begin
        arst_n      = 1'b0;
        fetch_req   = 1'b0;
        fetch_addr  = '0;
        busy_start  = 1'b0;
        busy_cycles = 8'd0;
        latency     = 8'd3;
        for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
            ref_valid[0][s] = 1'b0;
            ref_valid[1][s] = 1'b0;
            ref_lru[s]      = 1'b0;
        end
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        cold_misses();
        line_hits();
        lru_replace();
        busy_hold();
        random_fetches();
        $display("mismatches: %0d  other failures: %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/l2_model.sv
// level-2 line responder
`timescale 1ns/1ps
`default_nettype none

module l2_model (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     l2_req,
    input  wire icache_pkg::addr_t  l2_addr,
    input  wire                     busy_start,    // opens a busy window
    input  wire [7:0]               busy_cycles,
    input  wire [7:0]               latency,       // extra cycles before l2_rdy
    output logic                    l2_busy,
    output logic                    l2_rdy,
    output icache_pkg::line_t       l2_line
);

    logic              req_seen = 1'b0;
    logic              arm_seen = 1'b0;
    icache_pkg::addr_t req_addr;
    icache_pkg::addr_t line_addr;
    int                busy_left;
    int                wait_left;
    logic              pending;

    // inputs sampled on the rising edge
    always @(posedge clk) begin
        req_seen <= l2_req;
        arm_seen <= busy_start;
        req_addr <= l2_addr;
    end

    // outputs change on the falling edge
    always @(negedge clk or negedge arst_n) begin
        if (!arst_n) begin
            l2_busy   <= 1'b0;
            l2_rdy    <= 1'b0;
            l2_line   <= '0;
            busy_left = 0;
            wait_left = 0;
            pending   = 1'b0;
        end else begin
            l2_rdy <= 1'b0;
            if (arm_seen) begin
                busy_left = busy_cycles;
            end
            l2_busy <= (busy_left > 0);
            if (busy_left > 0) begin
                busy_left--;
            end
            if (req_seen) begin
                pending   = 1'b1;
                line_addr = req_addr;
                wait_left = latency;
            end
            if (pending && wait_left == 0) begin
                for (int k = 0; k < 4; k++) begin
                    l2_line[32*k +: 32] <= line_addr ^ (k * 32'h01010101);   // line rule
                end
                l2_rdy  <= 1'b1;
                pending = 1'b0;
            end else if (pending) begin
                wait_left--;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/icache_top.sv
// instruction cache top
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         fetch_req,
    input  wire icache_pkg::addr_t      fetch_addr,
    input  wire                         l2_busy,
    input  wire                         l2_rdy,
    input  wire icache_pkg::line_t      l2_line,
    output icache_pkg::word_t           fetch_word,
    output logic                        data_rdy,
    output logic                        miss_stall,
    output logic                        l2_req,
    output icache_pkg::addr_t           l2_addr
);

    icache_pkg::fetch_fields_t fetch_fields;
    icache_pkg::tag_entry_t    tag0;
    icache_pkg::tag_entry_t    tag1;
    icache_pkg::line_t         line0;
    icache_pkg::line_t         line1;
    icache_pkg::way_t          lru;
    icache_pkg::fill_cmd_t     fill_cmd;
    icache_pkg::way_t          touch_way;
    icache_pkg::way_t          hit_way;
    logic                      lookup;
    logic                      busy;
    logic                      touch;
    logic                      hit;
    logic                      refill_done;

    fetch_latch u_fetch_latch (
        .clk          (clk),
        .arst_n       (arst_n),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .busy         (busy),
        .fetch_fields (fetch_fields),
        .lookup       (lookup)
    );

    icache_ways u_ways (
        .clk       (clk),
        .arst_n    (arst_n),
        .index     (fetch_fields.index),
        .fill_cmd  (fill_cmd),
        .touch     (touch),
        .touch_way (touch_way),
        .tag0      (tag0),
        .tag1      (tag1),
        .line0     (line0),
        .line1     (line1),
        .lru       (lru)
    );

    icache_ctrl u_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .lookup       (lookup),
        .fetch_fields (fetch_fields),
        .tag0         (tag0),
        .tag1         (tag1),
        .lru          (lru),
        .l2_rdy       (l2_rdy),
        .l2_line      (l2_line),
        .l2_busy      (l2_busy),
        .l2_req       (l2_req),
        .l2_addr      (l2_addr),
        .miss_stall   (miss_stall),
        .busy         (busy),
        .fill_cmd     (fill_cmd),
        .touch        (touch),
        .touch_way    (touch_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .refill_done  (refill_done)
    );

    word_select u_word_select (
        .clk         (clk),
        .arst_n      (arst_n),
        .offset      (fetch_fields.offset),
        .hit         (hit),
        .hit_way     (hit_way),
        .line0       (line0),
        .line1       (line1),
        .refill_done (refill_done),
        .l2_line     (l2_line),
        .fetch_word  (fetch_word),
        .data_rdy    (data_rdy)
    );

endmodule

`default_nettype wire

//--- logic/word_select.sv
// fetch word select
`timescale 1ns/1ps
`default_nettype none

module word_select (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire icache_pkg::offset_t    offset,
    input  wire                         hit,
    input  wire icache_pkg::way_t       hit_way,
    input  wire icache_pkg::line_t      line0,
    input  wire icache_pkg::line_t      line1,
    input  wire                         refill_done,
    input  wire icache_pkg::line_t      l2_line,
    output icache_pkg::word_t           fetch_word,
    output logic                        data_rdy
);

    icache_pkg::line_t src_line;
    icache_pkg::word_t src_word;
    logic              load;

    assign load = hit || refill_done;

    always_comb begin
        if (refill_done) begin
            src_line = l2_line;   // bypass the arrays on refill
        end else if (hit_way) begin
            src_line = line1;
        end else begin
            src_line = line0;
        end
        src_word = src_line[{offset, 5'b00000} +: 32];
    end

    always_ff @(posedge clk) begin
        if (load) begin
            fetch_word <= src_word;
        end
    end

    // one cycle per delivered word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_rdy <= 1'b0;
        end else begin
            data_rdy <= load;
        end
    end

endmodule

`default_nettype wire

//--- logic/icache_ctrl.sv
// cache hit check and miss control
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  wire                             clk,
    input  wire                             arst_n,
    input  wire                             lookup,
    input  wire icache_pkg::fetch_fields_t  fetch_fields,
    input  wire icache_pkg::tag_entry_t     tag0,
    input  wire icache_pkg::tag_entry_t     tag1,
    input  wire icache_pkg::way_t           lru,
    input  wire                             l2_rdy,
    input  wire icache_pkg::line_t          l2_line,
    input  wire                             l2_busy,
    output logic                            l2_req,
    output icache_pkg::addr_t               l2_addr,
    output logic                            miss_stall,
    output logic                            busy,
    output icache_pkg::fill_cmd_t           fill_cmd,
    output logic                            touch,
    output icache_pkg::way_t                touch_way,
    output logic                            hit,
    output icache_pkg::way_t                hit_way,
    output logic                            refill_done
);

    icache_pkg::ctrl_state_t state_q;
    icache_pkg::ctrl_state_t state_d;
    icache_pkg::way_t        victim_c;
    icache_pkg::way_t        victim_q;   // held for the fill
    logic                    hit0;
    logic                    hit1;
    logic                    miss;
    logic                    do_fill;

    // tag compare, qualified by valid
    assign hit0 = tag0.valid && (tag0.tag == fetch_fields.tag);
    assign hit1 = tag1.valid && (tag1.tag == fetch_fields.tag);
    assign hit_way = hit0 ? 1'b0 : 1'b1;

    assign miss = lookup && !(hit0 || hit1) && (state_q == icache_pkg::st_lookup);

    // empty way first, way 0 before way 1, then lru
    always_comb begin
        if (!tag0.valid) begin
            victim_c = 1'b0;
        end else if (!tag1.valid) begin
            victim_c = 1'b1;
        end else begin
            victim_c = lru;
        end
    end

    always_comb begin
        state_d = state_q;
        l2_req  = 1'b0;
        hit     = 1'b0;
        do_fill = 1'b0;
        case (state_q)
            icache_pkg::st_lookup: begin
                if (lookup) begin
                    if (hit0 || hit1) begin
                        hit = 1'b1;
                    end else if (l2_busy) begin
                        state_d = icache_pkg::st_wait_busy;
                    end else begin
                        l2_req  = 1'b1;   // straight to refill
                        state_d = icache_pkg::st_refill;
                    end
                end
            end
            icache_pkg::st_wait_busy: begin
                if (!l2_busy) begin
                    l2_req  = 1'b1;
                    state_d = icache_pkg::st_refill;
                end
            end
            icache_pkg::st_refill: begin
                // line written in the cycle it arrives
                if (l2_rdy) begin
                    do_fill = 1'b1;
                    state_d = icache_pkg::st_fill;
                end
            end
            icache_pkg::st_fill: begin
                state_d = icache_pkg::st_lookup;   // word leaves this cycle
            end
            default: begin
                state_d = icache_pkg::st_lookup;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= icache_pkg::st_lookup;
        end else begin
            state_q <= state_d;
        end
    end

    // arrays are stable through the miss, victim taken at lookup
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            victim_q <= 1'b0;
        end else if (miss) begin
            victim_q <= victim_c;
        end
    end

    // stall covers the whole level-2 wait
    assign miss_stall = (state_q == icache_pkg::st_wait_busy) ||
                        (state_q == icache_pkg::st_refill);

    // keeps the fetch fields frozen
    assign busy = lookup || miss_stall;

    assign l2_addr = {fetch_fields.tag, fetch_fields.index, 4'b0000};   // line aligned

    assign refill_done = do_fill;
    assign touch       = hit || do_fill;
    assign touch_way   = do_fill ? victim_q : hit_way;

    always_comb begin
        fill_cmd.wr          = do_fill;
        fill_cmd.way         = victim_q;
        fill_cmd.index       = fetch_fields.index;
        fill_cmd.entry.valid = 1'b1;
        fill_cmd.entry.tag   = fetch_fields.tag;
        fill_cmd.line        = l2_line;
    end

endmodule

`default_nettype wire

//--- logic/icache_ways.sv
// two-way tag and data arrays
`timescale 1ns/1ps
`default_nettype none

module icache_ways (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire icache_pkg::index_t      index,
    input  wire icache_pkg::fill_cmd_t   fill_cmd,
    input  wire                          touch,
    input  wire icache_pkg::way_t        touch_way,
    output icache_pkg::tag_entry_t       tag0,
    output icache_pkg::tag_entry_t       tag1,
    output icache_pkg::line_t            line0,
    output icache_pkg::line_t            line1,
    output icache_pkg::way_t             lru
);

    // valid bits per way, cleared on reset
    logic [1:0][icache_pkg::NUM_SETS-1:0] valid_q;

    // lru bit per set names the way to replace next
    logic [icache_pkg::NUM_SETS-1:0] lru_q;

    icache_pkg::tag_t  tag_mem  [2][icache_pkg::NUM_SETS];
    icache_pkg::line_t data_mem [2][icache_pkg::NUM_SETS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (fill_cmd.wr) begin
            valid_q[fill_cmd.way][fill_cmd.index] <= fill_cmd.entry.valid;
        end
    end

    // a used way makes the other one the replacement candidate
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lru_q <= '0;
        end else if (touch) begin
            lru_q[index] <= ~touch_way;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_cmd.wr) begin
            tag_mem[fill_cmd.way][fill_cmd.index]  <= fill_cmd.entry.tag;
            data_mem[fill_cmd.way][fill_cmd.index] <= fill_cmd.line;
        end
    end

    // asynchronous read at the held index
    always_comb begin
        tag0.valid = valid_q[0][index];
        tag0.tag   = tag_mem[0][index];
        tag1.valid = valid_q[1][index];
        tag1.tag   = tag_mem[1][index];
        line0      = data_mem[0][index];
        line1      = data_mem[1][index];
        lru        = lru_q[index];
    end

endmodule

`default_nettype wire

//--- logic/fetch_latch.sv
// fetch address latch
`timescale 1ns/1ps
`default_nettype none

module fetch_latch (
    input  wire                           clk,
    input  wire                           arst_n,
    input  wire                           fetch_req,
    input  wire icache_pkg::addr_t        fetch_addr,
    input  wire                           busy,
    output icache_pkg::fetch_fields_t     fetch_fields,
    output logic                          lookup
);

    logic capture;

    // requests while a lookup or miss is in flight are dropped
    assign capture = fetch_req && !busy;

    // fields stay put until the next accepted request,
    // so the arrays keep reading the same set through a miss
    always_ff @(posedge clk) begin
        if (capture) begin
            fetch_fields.tag    <= fetch_addr[31:12];
            fetch_fields.index  <= fetch_addr[11:4];
            fetch_fields.offset <= fetch_addr[3:2];
        end
    end

    // lookup strobe one cycle after the request
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lookup <= 1'b0;
        end else begin
            lookup <= capture;
        end
    end

endmodule

`default_nettype wire

//--- logic/icache_pkg.sv
// instruction cache types
`default_nettype none

package icache_pkg;

    localparam int NUM_SETS = 256;   // one set per index_t value

    typedef logic [31:0]  addr_t;    // byte address
    typedef logic [31:0]  word_t;
    typedef logic [127:0] line_t;    // word k in bits 32k+31:32k
    typedef logic [19:0]  tag_t;     // addr[31:12]
    typedef logic [7:0]   index_t;   // addr[11:4]
    typedef logic [1:0]   offset_t;  // addr[3:2]
    typedef logic         way_t;

    // addr[1:0] not kept
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } fetch_fields_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // line write into the victim way
    typedef struct packed {
        logic       wr;
        way_t       way;
        index_t     index;
        tag_entry_t entry;
        line_t      line;
    } fill_cmd_t;

    typedef enum logic [1:0] {
        st_lookup,
        st_wait_busy,
        st_refill,
        st_fill
    } ctrl_state_t;

endpackage

`default_nettype wire
